// File: axi_fw_pkg.sv
package axi_fw_pkg;

    localparam int NUM_RULES = 8;
    localparam int FIFO_DEPTH = 4;
    localparam int ADDR_W = 32;
    localparam logic [7:0] KILL_MAX = 8'd255;

    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int RULE_SEL_W = $clog2(NUM_RULES);
    // wide enough to hold NUM_RULES itself, which stands for the default action
    localparam int RULE_ID_W = 4;

    // apb register offsets
    localparam logic [15:0] REG_CTRL = 16'h000;
    localparam logic [15:0] REG_STATUS = 16'h004;
    localparam logic [15:0] REG_KILLS = 16'h008;
    localparam logic [15:0] REG_WR_ADDR = 16'h00c;
    localparam logic [15:0] REG_WR_INFO = 16'h010;
    localparam logic [15:0] REG_RD_ADDR = 16'h014;
    localparam logic [15:0] REG_RD_INFO = 16'h018;
    localparam logic [15:0] RULE_BASE = 16'h100;
    localparam int RULE_STRIDE = 16;

    typedef logic [RULE_ID_W-1:0] fw_rule_id_t;

    typedef enum logic {
        pass = 1'b0,
        kill = 1'b1
    } fw_action_e;

    typedef struct packed {
        logic [3:0] id;
        logic [ADDR_W-1:0] addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
        logic [3:0] cache;
        logic [3:0] qos;
        logic [2:0] prot;
    } axi_fw_req_t;

    typedef struct packed {
        logic valid;
        fw_action_e action;
        logic [ADDR_W-1:0] base;
        logic [ADDR_W-1:0] limit;
    } fw_rule_t;

    typedef struct packed {
        logic enable;
        fw_action_e default_action;
        fw_rule_t [NUM_RULES-1:0] rules;
    } fw_cfg_t;

    typedef struct packed {
        logic caught;
        logic [ADDR_W-1:0] caught_addr;
        logic [3:0] caught_id;
        fw_rule_id_t caught_rule;
        logic [7:0] kill_count;
    } fw_status_t;

endpackage

// File: axi_fw_fifo.sv
module axi_fw_fifo (
    input logic clk,
    input logic rst_n,
    input logic push,
    input axi_fw_pkg::axi_fw_req_t din,
    input logic pop,
    output axi_fw_pkg::axi_fw_req_t dout,
    output logic full,
    output logic empty
);

    axi_fw_pkg::axi_fw_req_t mem [axi_fw_pkg::FIFO_DEPTH];

    logic [axi_fw_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [axi_fw_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [axi_fw_pkg::FIFO_PTR_W:0] count;
    logic push_ok;
    logic pop_ok;

    assign full = (count == axi_fw_pkg::FIFO_DEPTH);
    assign empty = (count == 0);
    assign push_ok = push && !full;
    assign pop_ok = pop && !empty;
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == axi_fw_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == axi_fw_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({push_ok, pop_ok})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: axi_fw_judge.sv
module axi_fw_judge (
    input logic clk,
    input logic rst_n,
    input logic head_valid,
    input axi_fw_pkg::axi_fw_req_t head,
    output logic head_pop,
    input axi_fw_pkg::fw_cfg_t cfg,
    input logic out_full,
    output logic fwd_push,
    output axi_fw_pkg::axi_fw_req_t fwd_req,
    output logic kill_evt,
    output logic [3:0] kill_rule
);

    logic vld_q;
    axi_fw_pkg::axi_fw_req_t req_q;
    axi_fw_pkg::fw_action_e act_q;
    axi_fw_pkg::fw_rule_id_t rule_q;

    axi_fw_pkg::fw_action_e match_act;
    axi_fw_pkg::fw_rule_id_t match_rule;
    logic leaving;

    // walk downwards so the lowest-numbered hit is the one left standing
    always_comb begin
        match_act = cfg.default_action;
        match_rule = axi_fw_pkg::fw_rule_id_t'(axi_fw_pkg::NUM_RULES);
        for (int i = axi_fw_pkg::NUM_RULES - 1; i >= 0; i--) begin
            if (cfg.rules[i].valid &&
                head.addr >= cfg.rules[i].base &&
                head.addr <= cfg.rules[i].limit) begin
                match_act = cfg.rules[i].action;
                match_rule = axi_fw_pkg::fw_rule_id_t'(i);
            end
        end
        if (!cfg.enable) begin
            match_act = axi_fw_pkg::pass;
        end
    end

    assign fwd_push = vld_q && (act_q == axi_fw_pkg::pass) && !out_full;
    assign kill_evt = vld_q && (act_q == axi_fw_pkg::kill);
    assign leaving = fwd_push || kill_evt;
    assign head_pop = head_valid && (!vld_q || leaving);
    assign fwd_req = req_q;
    assign kill_rule = rule_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else if (head_pop) begin
            vld_q <= 1'b1;
        end else if (leaving) begin
            vld_q <= 1'b0;
        end
    end

    // decision is frozen at load time
    always_ff @(posedge clk) begin
        if (head_pop) begin
            req_q <= head;
            act_q <= match_act;
            rule_q <= match_rule;
        end
    end

endmodule

// File: axi_fw_channel.sv
module axi_fw_channel (
    input logic clk,
    input logic rst_n,
    input axi_fw_pkg::axi_fw_req_t sl_req,
    input logic sl_valid,
    output logic sl_ready,
    output axi_fw_pkg::axi_fw_req_t ms_req,
    output logic ms_valid,
    input logic ms_ready,
    input axi_fw_pkg::fw_cfg_t cfg,
    input logic clear,
    output axi_fw_pkg::fw_status_t status
);

    axi_fw_pkg::axi_fw_req_t head;
    axi_fw_pkg::axi_fw_req_t fwd_req;
    logic in_full;
    logic in_empty;
    logic head_pop;
    logic out_full;
    logic out_empty;
    logic fwd_push;
    logic kill_evt;
    logic [3:0] kill_rule;

    assign sl_ready = !in_full;
    assign ms_valid = !out_empty;

    axi_fw_fifo u_in_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (sl_valid),
        .din   (sl_req),
        .pop   (head_pop),
        .dout  (head),
        .full  (in_full),
        .empty (in_empty)
    );

    axi_fw_judge u_judge (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (!in_empty),
        .head       (head),
        .head_pop   (head_pop),
        .cfg        (cfg),
        .out_full   (out_full),
        .fwd_push   (fwd_push),
        .fwd_req    (fwd_req),
        .kill_evt   (kill_evt),
        .kill_rule  (kill_rule)
    );

    axi_fw_fifo u_out_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (fwd_push),
        .din   (fwd_req),
        .pop   (ms_ready),
        .dout  (ms_req),
        .full  (out_full),
        .empty (out_empty)
    );

    // kill counter and first-kill capture, clear wins over a kill
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status <= '0;
        end else if (clear) begin
            status <= '0;
        end else if (kill_evt) begin
            if (status.kill_count != axi_fw_pkg::KILL_MAX) begin
                status.kill_count <= status.kill_count + 1'b1;
            end
            if (!status.caught) begin
                status.caught <= 1'b1;
                status.caught_addr <= fwd_req.addr;
                status.caught_id <= fwd_req.id;
                status.caught_rule <= kill_rule;
            end
        end
    end

endmodule

// File: axi_fw_regs.sv
module axi_fw_regs (
    input logic clk,
    input logic rst_n,
    input logic [15:0] paddr,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    output axi_fw_pkg::fw_cfg_t cfg,
    input axi_fw_pkg::fw_status_t wr_status,
    input axi_fw_pkg::fw_status_t rd_status,
    output logic wr_clear,
    output logic rd_clear
);

    axi_fw_pkg::fw_cfg_t cfg_q;
    logic access;
    logic wr_access;
    logic mapped;
    logic [15:0] rule_off;
    logic rule_hit;
    logic [axi_fw_pkg::RULE_SEL_W-1:0] rule_sel;
    logic [1:0] rule_reg;
    logic [31:0] rdata;

    assign access = psel && penable;
    assign wr_access = access && pwrite;
    assign pready = 1'b1;
    assign cfg = cfg_q;

    // rule window, addresses below RULE_BASE wrap to a large offset
    assign rule_off = paddr - axi_fw_pkg::RULE_BASE;
    assign rule_sel = rule_off[4 +: axi_fw_pkg::RULE_SEL_W];
    assign rule_reg = rule_off[3:2];
    assign rule_hit = (rule_off < axi_fw_pkg::NUM_RULES * axi_fw_pkg::RULE_STRIDE) &&
                      (rule_off[1:0] == 2'b00) && (rule_reg != 2'd3);

    // any write to status clears both channels
    assign wr_clear = wr_access && (paddr == axi_fw_pkg::REG_STATUS);
    assign rd_clear = wr_access && (paddr == axi_fw_pkg::REG_STATUS);

    always_comb begin
        mapped = 1'b1;
        rdata = '0;
        case (paddr)
            axi_fw_pkg::REG_CTRL: rdata = {30'b0, cfg_q.default_action, cfg_q.enable};
            axi_fw_pkg::REG_STATUS: rdata = {30'b0, rd_status.caught, wr_status.caught};
            axi_fw_pkg::REG_KILLS: rdata = {16'b0, rd_status.kill_count, wr_status.kill_count};
            axi_fw_pkg::REG_WR_ADDR: rdata = wr_status.caught_addr;
            axi_fw_pkg::REG_WR_INFO:
                rdata = {20'b0, wr_status.caught_rule, 4'b0, wr_status.caught_id};
            axi_fw_pkg::REG_RD_ADDR: rdata = rd_status.caught_addr;
            axi_fw_pkg::REG_RD_INFO:
                rdata = {20'b0, rd_status.caught_rule, 4'b0, rd_status.caught_id};
            default: begin
                mapped = rule_hit;
                case (rule_reg)
                    2'd0: rdata = cfg_q.rules[rule_sel].base;
                    2'd1: rdata = cfg_q.rules[rule_sel].limit;
                    default: begin
                        rdata = {30'b0, cfg_q.rules[rule_sel].action,
                                 cfg_q.rules[rule_sel].valid};
                    end
                endcase
                if (!rule_hit) begin
                    rdata = '0;
                end
            end
        endcase
    end

    assign prdata = rdata;
    assign pslverr = access && !mapped;

    // status and capture registers are read only, writes to them are ignored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q <= '0;
        end else if (wr_access) begin
            if (paddr == axi_fw_pkg::REG_CTRL) begin
                cfg_q.enable <= pwdata[0];
                cfg_q.default_action <= axi_fw_pkg::fw_action_e'(pwdata[1]);
            end
            if (rule_hit) begin
                case (rule_reg)
                    2'd0: cfg_q.rules[rule_sel].base <= pwdata;
                    2'd1: cfg_q.rules[rule_sel].limit <= pwdata;
                    default: begin
                        cfg_q.rules[rule_sel].valid <= pwdata[0];
                        cfg_q.rules[rule_sel].action <= axi_fw_pkg::fw_action_e'(pwdata[1]);
                    end
                endcase
            end
        end
    end

endmodule

// File: axi_firewall.sv
module axi_firewall (
    input logic clk,
    input logic rst_n,
    input axi_fw_pkg::axi_fw_req_t sl_aw,
    input logic sl_awvalid,
    output logic sl_awready,
    input axi_fw_pkg::axi_fw_req_t sl_ar,
    input logic sl_arvalid,
    output logic sl_arready,
    output axi_fw_pkg::axi_fw_req_t ms_aw,
    output logic ms_awvalid,
    input logic ms_awready,
    output axi_fw_pkg::axi_fw_req_t ms_ar,
    output logic ms_arvalid,
    input logic ms_arready,
    // secure apb slave
    input logic [15:0] paddr,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr
);

    axi_fw_pkg::fw_cfg_t cfg;
    axi_fw_pkg::fw_status_t wr_status;
    axi_fw_pkg::fw_status_t rd_status;
    logic wr_clear;
    logic rd_clear;

    axi_fw_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cfg       (cfg),
        .wr_status (wr_status),
        .rd_status (rd_status),
        .wr_clear  (wr_clear),
        .rd_clear  (rd_clear)
    );

    // both channels judge against the same rule table
    axi_fw_channel u_wr_channel (
        .clk      (clk),
        .rst_n    (rst_n),
        .sl_req   (sl_aw),
        .sl_valid (sl_awvalid),
        .sl_ready (sl_awready),
        .ms_req   (ms_aw),
        .ms_valid (ms_awvalid),
        .ms_ready (ms_awready),
        .cfg      (cfg),
        .clear    (wr_clear),
        .status   (wr_status)
    );

    axi_fw_channel u_rd_channel (
        .clk      (clk),
        .rst_n    (rst_n),
        .sl_req   (sl_ar),
        .sl_valid (sl_arvalid),
        .sl_ready (sl_arready),
        .ms_req   (ms_ar),
        .ms_valid (ms_arvalid),
        .ms_ready (ms_arready),
        .cfg      (cfg),
        .clear    (rd_clear),
        .status   (rd_status)
    );

endmodule

// File: tb_axi_firewall.sv
module tb_axi_firewall;

    timeunit 1ns;
    timeprecision 1ps;

    logic clk;
    logic rst_n;
    axi_fw_pkg::axi_fw_req_t sl_aw;
    logic sl_awvalid;
    logic sl_awready;
    axi_fw_pkg::axi_fw_req_t sl_ar;
    logic sl_arvalid;
    logic sl_arready;
    axi_fw_pkg::axi_fw_req_t ms_aw;
    logic ms_awvalid;
    logic ms_awready;
    axi_fw_pkg::axi_fw_req_t ms_ar;
    logic ms_arvalid;
    logic ms_arready;
    logic [15:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;

    // reference model with the write channel at index 0
    axi_fw_pkg::axi_fw_req_t exp_w[$];
    axi_fw_pkg::axi_fw_req_t exp_r[$];
    logic [7:0] kills [2];
    logic caught [2];
    logic [31:0] c_addr [2];
    logic [3:0] c_id [2];
    logic [3:0] c_rule [2];
    logic m_enable;
    logic m_def_kill;
    logic m_valid [8];
    logic m_kill [8];
    logic [31:0] m_base [8];
    logic [31:0] m_limit [8];

    int errors;
    int checks;
    // 0 gives random ms ready and 1 holds it low
    int ready_mode;
    // 0 for any address, 1 around the windows and 2 for the kill window only
    int addr_mode;

    axi_firewall u_axi_firewall (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50;
            clk = ~clk;
        end
    end

    assert property (@(posedge clk) !rst_n |-> !ms_awvalid && !ms_arvalid)
        else begin
            errors++;
            $display("error at %0t: ms valid was high during reset", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        ms_awvalid && !ms_awready |=> ms_awvalid && $stable(ms_aw))
        else begin
            errors++;
            $display("error at %0t: ms_aw changed or dropped before ms_awready", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        ms_arvalid && !ms_arready |=> ms_arvalid && $stable(ms_ar))
        else begin
            errors++;
            $display("error at %0t: ms_ar changed or dropped before ms_arready", $time);
        end

    assert property (@(posedge clk) pready)
        else begin
            errors++;
            $display("error at %0t: pready was low", $time);
        end

    always @(posedge clk) begin
        if (rst_n) begin
            if (sl_awvalid && sl_awready) begin
                expect_in(0, sl_aw);
            end
            if (sl_arvalid && sl_arready) begin
                expect_in(1, sl_ar);
            end
            if (ms_awvalid && ms_awready) begin
                match_out(0, ms_aw);
            end
            if (ms_arvalid && ms_arready) begin
                match_out(1, ms_ar);
            end
        end
    end

    task automatic drive_ready();
        forever begin
            @(posedge clk);
            if (ready_mode == 1) begin
                ms_awready <= 1'b0;
                ms_arready <= 1'b0;
            end else begin
                ms_awready <= ($urandom_range(0, 3) != 0);
                ms_arready <= ($urandom_range(0, 3) != 0);
            end
        end
    endtask

    // first valid rule containing addr wins
    // 8 when no rule hits
    function automatic int decide(input logic [31:0] addr, output logic killed);
        killed = 1'b0;
        if (!m_enable) begin
            return 8;
        end
        for (int i = 0; i < 8; i++) begin
            if (m_valid[i] && addr >= m_base[i] && addr <= m_limit[i]) begin
                killed = m_kill[i];
                return i;
            end
        end
        killed = m_def_kill;
        return 8;
    endfunction

    function automatic logic [31:0] pick_addr();
        logic [31:0] r;
        r = $urandom;
        if (addr_mode == 0) begin
            return r;
        end
        if (addr_mode == 2) begin
            return 32'h2000_0000 | (r & 32'h0fff_ffff);
        end
        case ($urandom_range(0, 4))
            0: return 32'h1000_0000 | (r & 32'h0000_0fff);
            1: return 32'h1000_0000 | (r & 32'h0fff_ffff);
            2: return 32'h2000_0000 | (r & 32'h0fff_ffff);
            3: return 32'h4000_0000 | (r & 32'h0000_ffff);
            default: return 32'h8000_0000 | (r & 32'h0fff_ffff);
        endcase
    endfunction

    function automatic axi_fw_pkg::axi_fw_req_t rand_req();
        logic [63:0] bits;
        axi_fw_pkg::axi_fw_req_t r;
        bits = {$urandom, $urandom};
        r = bits[59:0];
        r.addr = pick_addr();
        return r;
    endfunction

    task automatic expect_in(input int ch, input axi_fw_pkg::axi_fw_req_t r);
        logic killed;
        int rule;
        rule = decide(r.addr, killed);
        if (!killed) begin
            if (ch == 0) begin
                exp_w.push_back(r);
            end else begin
                exp_r.push_back(r);
            end
        end else begin
            if (kills[ch] != 8'd255) begin
                kills[ch]++;
            end
            if (!caught[ch]) begin
                caught[ch] = 1'b1;
                c_addr[ch] = r.addr;
                c_id[ch] = r.id;
                c_rule[ch] = rule[3:0];
            end
        end
    endtask

    task automatic match_out(input int ch, input axi_fw_pkg::axi_fw_req_t got);
        axi_fw_pkg::axi_fw_req_t exp;
        int n;
        n = (ch == 0) ? exp_w.size() : exp_r.size();
        checks++;
        assert (n > 0) else begin
            errors++;
            $display("error at %0t: channel %0d forwarded an unexpected request", $time, ch);
        end
        if (n > 0) begin
            if (ch == 0) begin
                exp = exp_w.pop_front();
            end else begin
                exp = exp_r.pop_front();
            end
            assert (got == exp) else begin
                errors++;
                $display("error at %0t: %s got %h expected %h", $time,
                         (ch == 0) ? "ms_aw" : "ms_ar", got, exp);
            end
        end
    endtask

    task automatic clear_records();
        for (int ch = 0; ch < 2; ch++) begin
            kills[ch] = 8'd0;
            caught[ch] = 1'b0;
            c_addr[ch] = '0;
            c_id[ch] = '0;
            c_rule[ch] = '0;
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic give_up(input string msg);
        errors++;
        $display("timeout at %0t: %s", $time, msg);
        finish_run();
    endtask

    task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int t;
        t = 0;
        @(posedge clk);
        paddr <= addr;
        pwrite <= wr;
        pwdata <= wdata;
        psel <= 1'b1;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        while (!pready && t < 16) begin
            @(posedge clk);
            t++;
        end
        if (!pready) begin
            give_up("APB transfer never completed");
        end else begin
            rdata = prdata;
            err = pslverr;
            psel <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic err;
        int i;
        apb_xfer(1'b1, addr, data, unused, err);
        checks++;
        assert (!err) else begin
            errors++;
            $display("error at %0t: pslverr on write to %h got %b expected 0", $time, addr,
                     err);
        end
        i = int'(addr[6:4]);
        if (addr == 16'h000) begin
            m_enable = data[0];
            m_def_kill = data[1];
        end else if (addr == 16'h004) begin
            clear_records();
        end else if (addr >= 16'h100 && addr < 16'h180) begin
            case (addr[3:0])
                4'h0: m_base[i] = data;
                4'h4: m_limit[i] = data;
                4'h8: begin
                    m_valid[i] = data[0];
                    m_kill[i] = data[1];
                end
                default: ;
            endcase
        end
    endtask

    task automatic check_reg(input logic [15:0] addr, input logic [31:0] exp,
                             input logic exp_err, input string name);
        logic [31:0] got;
        logic err;
        apb_xfer(1'b0, addr, 32'h0, got, err);
        checks++;
        assert (err == exp_err && (exp_err || got == exp)) else begin
            errors++;
            $display("error at %0t: %s at %h got %h/%b expected %h/%b", $time, name, addr,
                     got, err, exp, exp_err);
        end
    endtask

    task automatic check_status();
        check_reg(16'h004, {30'b0, caught[1], caught[0]}, 1'b0, "status");
        check_reg(16'h008, {16'b0, kills[1], kills[0]}, 1'b0, "kill counts");
        check_reg(16'h00c, c_addr[0], 1'b0, "write caught addr");
        check_reg(16'h010, {20'b0, c_rule[0], 4'b0, c_id[0]}, 1'b0, "write caught info");
        check_reg(16'h014, c_addr[1], 1'b0, "read caught addr");
        check_reg(16'h018, {20'b0, c_rule[1], 4'b0, c_id[1]}, 1'b0, "read caught info");
    endtask

    task automatic set_rule(input int i, input logic [31:0] base, input logic [31:0] limit,
                            input logic [1:0] ctrl);
        logic [15:0] a;
        a = 16'h100 + 16'(i * 16);
        apb_write(a, base);
        apb_write(a + 16'h4, limit);
        apb_write(a + 16'h8, {30'b0, ctrl});
        check_reg(a, base, 1'b0, "rule base");
        check_reg(a + 16'h4, limit, 1'b0, "rule limit");
        check_reg(a + 16'h8, {30'b0, ctrl}, 1'b0, "rule control");
    endtask

    task automatic send_requests(input int n);
        int sent_w;
        int sent_r;
        int t;
        sent_w = 0;
        sent_r = 0;
        t = 0;
        @(posedge clk);
        sl_aw <= rand_req();
        sl_awvalid <= 1'b1;
        sl_ar <= rand_req();
        sl_arvalid <= 1'b1;
        while ((sent_w < n || sent_r < n) && t < 20 * n + 100) begin
            @(posedge clk);
            t++;
            if (sl_awvalid && sl_awready) begin
                sent_w++;
                sl_aw <= rand_req();
                sl_awvalid <= (sent_w < n);
            end
            if (sl_arvalid && sl_arready) begin
                sent_r++;
                sl_ar <= rand_req();
                sl_arvalid <= (sent_r < n);
            end
        end
        if (sent_w < n || sent_r < n) begin
            give_up("slave side stopped accepting requests");
        end
    endtask

    // killed items leave no trace at the ms side so wait for a quiet stretch
    task automatic wait_drain();
        int t;
        int quiet;
        t = 0;
        quiet = 0;
        while (quiet < 8 && t < 4000) begin
            @(posedge clk);
            t++;
            if (exp_w.size() == 0 && exp_r.size() == 0 && !ms_awvalid && !ms_arvalid) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        if (quiet < 8) begin
            give_up("expected requests never reached the ms ports");
        end
    endtask

    task automatic wait_full();
        int t;
        t = 0;
        while ((sl_awready || sl_arready) && t < 50) begin
            @(posedge clk);
            t++;
        end
        if (sl_awready || sl_arready) begin
            give_up("sl ready stayed high with ms ready held low");
        end else begin
            checks++;
            assert (exp_w.size() == 9 && exp_r.size() == 9) else begin
                errors++;
                $display("error at %0t: held requests got %0d/%0d expected 9/9", $time,
                         exp_w.size(), exp_r.size());
            end
        end
    endtask

    initial begin
        void'($urandom(32'hfe9b_60f9));
        errors = 0;
        checks = 0;
        ready_mode = 0;
        addr_mode = 0;
        m_enable = 1'b0;
        m_def_kill = 1'b0;
        for (int i = 0; i < 8; i++) begin
            m_valid[i] = 1'b0;
            m_kill[i] = 1'b0;
            m_base[i] = '0;
            m_limit[i] = '0;
        end
        clear_records();
        rst_n <= 1'b0;
        sl_aw <= '0;
        sl_awvalid <= 1'b0;
        sl_ar <= '0;
        sl_arvalid <= 1'b0;
        ms_awready <= 1'b0;
        ms_arready <= 1'b0;
        paddr <= '0;
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
        pwdata <= '0;
        fork
            drive_ready();
        join_none
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // firewall off after reset
        send_requests(40);
        wait_drain();
        check_status();

        // rule 0 overlaps rule 1
        // rule 5 is not valid
        set_rule(0, 32'h1000_0000, 32'h1000_0fff, 2'b11);
        set_rule(1, 32'h1000_0000, 32'h1fff_ffff, 2'b01);
        set_rule(2, 32'h2000_0000, 32'h2fff_ffff, 2'b11);
        set_rule(3, 32'h4000_0000, 32'h4000_ffff, 2'b01);
        set_rule(5, 32'h8000_0000, 32'h8fff_ffff, 2'b10);
        check_reg(16'h01c, 32'h0, 1'b1, "pslverr");
        check_reg(16'h10c, 32'h0, 1'b1, "pslverr");
        check_reg(16'h180, 32'h0, 1'b1, "pslverr");
        check_reg(16'h002, 32'h0, 1'b1, "pslverr");

        apb_write(16'h000, 32'h1);
        check_reg(16'h000, 32'h1, 1'b0, "control");
        addr_mode = 1;
        send_requests(80);
        wait_drain();
        check_status();

        // unmatched addresses now dropped
        apb_write(16'h000, 32'h3);
        send_requests(60);
        wait_drain();
        check_status();
        apb_write(16'h004, 32'h0);
        check_status();

        // enough kills to saturate both counters
        addr_mode = 2;
        send_requests(270);
        wait_drain();
        check_status();
        apb_write(16'h004, 32'h1);

        // back-pressure with everything passing
        apb_write(16'h000, 32'h0);
        addr_mode = 0;
        ready_mode = 1;
        send_requests(9);
        wait_full();
        ready_mode = 0;
        wait_drain();
        check_status();
        finish_run();
    end

endmodule

// File: sources.f
axi_fw_pkg.sv
axi_fw_fifo.sv
axi_fw_judge.sv
axi_fw_channel.sv
axi_fw_regs.sv
axi_firewall.sv
tb_axi_firewall.sv

// File: Bender.yml
package:
  name: axi_firewall

sources:
  - axi_fw_pkg.sv
  - axi_fw_fifo.sv
  - axi_fw_judge.sv
  - axi_fw_channel.sv
  - axi_fw_regs.sv
  - axi_firewall.sv
  - target: test
    files:
      - tb_axi_firewall.sv
